// ==== design/corebus_pkg.sv ====
/*
  Shared definitions for the multi-port core bus memory target.
  Bus and memory widths, port count and packed channel widths.
  Command and response type enums.
  Command, write data and response channel structs.
  Memory controller state enum.
*/
package corebus_pkg;
  localparam int PORT_COUNT     = 2;
  localparam int PORT_SEL_WIDTH = 1;  // Width of a port index.

  localparam int ADDR_WIDTH     = 8;  // Word address.
  localparam int MEM_DEPTH      = 64;
  localparam int MEM_ADDR_WIDTH = $clog2(MEM_DEPTH);
  localparam int DATA_WIDTH     = 32;
  localparam int BE_WIDTH       = 4;
  localparam int BYTE_WIDTH     = DATA_WIDTH / BE_WIDTH;
  localparam int ID_WIDTH       = 4;
  localparam int LEN_WIDTH      = 2;  // Beat count minus one.

  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } corebus_command_type_e;

  typedef enum logic {
    RESP_READ  = 1'b0,
    RESP_WRITE = 1'b1
  } corebus_response_type_e;

  typedef struct packed {
    corebus_command_type_e  command_type;
    logic [ID_WIDTH-1:0]    id;
    logic [ADDR_WIDTH-1:0]  address;
    logic [LEN_WIDTH-1:0]   length;
  } corebus_command_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0]  data;
    logic [BE_WIDTH-1:0]    byte_enable;
    logic                   last;
  } corebus_write_data_t;

  typedef struct packed {
    corebus_response_type_e response_type;
    logic [ID_WIDTH-1:0]    id;
    logic [DATA_WIDTH-1:0]  data;
    logic                   error;  // Beat addressed past the end of memory.
    logic                   last;
  } corebus_response_t;

  localparam int COMMAND_WIDTH    = $bits(corebus_command_t);
  localparam int WRITE_DATA_WIDTH = $bits(corebus_write_data_t);
  localparam int RESPONSE_WIDTH   = $bits(corebus_response_t);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ,
    ST_READ_WAIT,
    ST_RESP
  } corebus_ctrl_state_e;
endpackage

// ==== design/corebus_request_arbiter.sv ====
/*
  Round-robin arbiter over the command channels of all ports.
  Picks one requesting port, latches its command and holds the
  grant until the memory controller releases it.
*/
`timescale 1ns/1ps
module corebus_request_arbiter (
  input   var logic                                   i_clk,
  input   var logic                                   i_rst,
  input   var logic [corebus_pkg::PORT_COUNT-1:0]     i_mcmd_valid,
  input   var corebus_pkg::corebus_command_t          i_mcmd [corebus_pkg::PORT_COUNT],
  input   var logic                                   i_release,
  output  var logic                                   o_request,
  output  var logic [corebus_pkg::PORT_SEL_WIDTH-1:0] o_grant_index,
  output  var corebus_pkg::corebus_command_t          o_command
);
  logic                                   granted;
  logic [corebus_pkg::PORT_SEL_WIDTH-1:0] grant_index;
  logic [corebus_pkg::PORT_SEL_WIDTH-1:0] rr_pointer;
  logic [corebus_pkg::PORT_SEL_WIDTH-1:0] next_pointer;
  logic                                   pick_found;
  logic [corebus_pkg::PORT_SEL_WIDTH-1:0] pick_index;
  corebus_pkg::corebus_command_t          command;

  // Search starts at the pointer and wraps around.
  always_comb begin
    int candidate;
    pick_found = 1'b0;
    pick_index = '0;
    for (int i = 0; i < corebus_pkg::PORT_COUNT; i++) begin
      candidate = (int'(rr_pointer) + i) % corebus_pkg::PORT_COUNT;
      if (!pick_found && i_mcmd_valid[candidate]) begin
        pick_found = 1'b1;
        pick_index = candidate[corebus_pkg::PORT_SEL_WIDTH-1:0];
      end
    end
  end

  always_comb begin
    if (int'(grant_index) == corebus_pkg::PORT_COUNT - 1) begin
      next_pointer = '0;
    end else begin
      next_pointer = grant_index + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      granted     <= 1'b0;
      grant_index <= '0;
      rr_pointer  <= '0;
    end else if (granted) begin
      if (i_release) begin
        granted    <= 1'b0;
        rr_pointer <= next_pointer;  // Winner drops to lowest priority.
      end
    end else if (pick_found) begin
      granted     <= 1'b1;
      grant_index <= pick_index;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!granted && pick_found) begin
      command <= i_mcmd[pick_index];
    end
  end

  always_comb begin
    o_request     = granted;
    o_grant_index = grant_index;
    o_command     = command;
  end
endmodule

// ==== design/corebus_memory_controller.sv ====
/*
  Memory controller FSM.
  Accepts the granted command, walks its beats, drives the memory
  port and hands one response per beat (one per write burst) to
  the response router. Out of range beats set the error flag.
*/
`timescale 1ns/1ps
module corebus_memory_controller (
  input   var logic                                   i_clk,
  input   var logic                                   i_rst,
  input   var logic                                   i_request,
  input   var corebus_pkg::corebus_command_t          i_command,
  input   var logic                                   i_mdata_valid,
  input   var corebus_pkg::corebus_write_data_t       i_mdata,
  input   var logic                                   i_resp_busy,
  output  var logic                                   o_cmd_accept,
  output  var logic                                   o_data_accept,
  output  var logic                                   o_release,
  output  var logic                                   o_mem_write,
  output  var logic                                   o_mem_read,
  output  var logic [corebus_pkg::MEM_ADDR_WIDTH-1:0] o_mem_addr,
  output  var logic [corebus_pkg::DATA_WIDTH-1:0]     o_mem_wdata,
  output  var logic [corebus_pkg::BE_WIDTH-1:0]       o_mem_be,
  output  var logic                                   o_resp_load,
  output  var corebus_pkg::corebus_response_t         o_resp
);
  corebus_pkg::corebus_ctrl_state_e     state;
  logic [corebus_pkg::LEN_WIDTH-1:0]    beat_count;
  logic                                 error_sticky;
  int                                   beat_sum;
  logic                                 beat_error;
  logic                                 beat_last;
  logic                                 read_issue;

  assign beat_sum   = int'(i_command.address) + int'(beat_count);
  assign beat_error = beat_sum >= corebus_pkg::MEM_DEPTH;
  assign beat_last  = beat_count == i_command.length;
  assign read_issue = (state == corebus_pkg::ST_READ) && !i_resp_busy;

  always_comb begin
    o_data_accept = (state == corebus_pkg::ST_WRITE) && i_mdata_valid;
    o_mem_write   = o_data_accept && !beat_error;
    o_mem_read    = read_issue && !beat_error;  // Bad beats return zero.
    o_mem_addr    = beat_sum[corebus_pkg::MEM_ADDR_WIDTH-1:0];
    o_mem_wdata   = i_mdata.data;
    o_mem_be      = i_mdata.byte_enable;
    // Last response must be taken before the grant moves on.
    o_release     = (state == corebus_pkg::ST_RESP) && !o_resp_load && !i_resp_busy;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state        <= corebus_pkg::ST_IDLE;
      o_cmd_accept <= 1'b0;
      o_resp_load  <= 1'b0;
      beat_count   <= '0;
      error_sticky <= 1'b0;
    end else begin
      case (state)
        corebus_pkg::ST_IDLE: begin
          if (o_cmd_accept) begin
            o_cmd_accept <= 1'b0;
            beat_count   <= '0;
            error_sticky <= 1'b0;
            if (i_command.command_type == corebus_pkg::CMD_WRITE) begin
              state <= corebus_pkg::ST_WRITE;
            end else begin
              state <= corebus_pkg::ST_READ;
            end
          end else if (i_request) begin
            o_cmd_accept <= 1'b1;  // One cycle pulse.
          end
        end
        corebus_pkg::ST_WRITE: begin
          if (i_mdata_valid) begin
            beat_count   <= beat_count + 1'b1;
            error_sticky <= error_sticky | beat_error;
            if (i_mdata.last) begin
              o_resp_load <= 1'b1;
              state       <= corebus_pkg::ST_RESP;
            end
          end
        end
        corebus_pkg::ST_READ: begin
          if (read_issue) begin
            o_resp_load <= 1'b1;  // Lines up with the registered read data.
            state       <= corebus_pkg::ST_READ_WAIT;
          end
        end
        corebus_pkg::ST_READ_WAIT: begin
          o_resp_load <= 1'b0;
          beat_count  <= beat_count + 1'b1;
          state       <= o_resp.last ? corebus_pkg::ST_RESP : corebus_pkg::ST_READ;
        end
        corebus_pkg::ST_RESP: begin
          o_resp_load <= 1'b0;
          if (o_release) begin
            state <= corebus_pkg::ST_IDLE;
          end
        end
        default: state <= corebus_pkg::ST_IDLE;
      endcase
    end
  end

  // Data field stays zero here and is filled by the router.
  always_ff @(posedge i_clk) begin
    if ((state == corebus_pkg::ST_WRITE) && i_mdata_valid && i_mdata.last) begin
      o_resp.response_type <= corebus_pkg::RESP_WRITE;
      o_resp.id            <= i_command.id;
      o_resp.data          <= '0;
      o_resp.error         <= error_sticky | beat_error;
      o_resp.last          <= 1'b1;
    end else if (read_issue) begin
      o_resp.response_type <= corebus_pkg::RESP_READ;
      o_resp.id            <= i_command.id;
      o_resp.data          <= '0;
      o_resp.error         <= beat_error;
      o_resp.last          <= beat_last;
    end
  end
endmodule

// ==== design/corebus_memory_array.sv ====
/*
  Single port storage, MEM_DEPTH words of DATA_WIDTH bits.
  Byte enabled writes and a registered read.
*/
`timescale 1ns/1ps
module corebus_memory_array (
  input   var logic                                   i_clk,
  input   var logic                                   i_write,
  input   var logic                                   i_read,
  input   var logic [corebus_pkg::MEM_ADDR_WIDTH-1:0] i_addr,
  input   var logic [corebus_pkg::DATA_WIDTH-1:0]     i_wdata,
  input   var logic [corebus_pkg::BE_WIDTH-1:0]       i_be,
  output  var logic [corebus_pkg::DATA_WIDTH-1:0]     o_rdata
);
  logic [corebus_pkg::DATA_WIDTH-1:0] mem [corebus_pkg::MEM_DEPTH];

  always_ff @(posedge i_clk) begin
    if (i_write) begin
      for (int b = 0; b < corebus_pkg::BE_WIDTH; b++) begin
        if (i_be[b]) begin
          mem[i_addr][b*corebus_pkg::BYTE_WIDTH+:corebus_pkg::BYTE_WIDTH] <=
            i_wdata[b*corebus_pkg::BYTE_WIDTH+:corebus_pkg::BYTE_WIDTH];
        end
      end
    end
  end

  // Data is ready in the cycle after the read.
  always_ff @(posedge i_clk) begin
    if (i_read) begin
      o_rdata <= mem[i_addr];
    end
  end
endmodule

// ==== design/corebus_response_router.sv ====
/*
  One entry response register.
  Merges read data into the response on load, raises valid on the
  granted port only and frees itself on that port's accept.
*/
`timescale 1ns/1ps
module corebus_response_router (
  input   var logic                                   i_clk,
  input   var logic                                   i_rst,
  input   var logic                                   i_load,
  input   var corebus_pkg::corebus_response_t         i_resp,
  input   var logic [corebus_pkg::DATA_WIDTH-1:0]     i_rdata,
  input   var logic [corebus_pkg::PORT_SEL_WIDTH-1:0] i_grant_index,
  input   var logic [corebus_pkg::PORT_COUNT-1:0]     i_mresp_accept,
  output  var logic                                   o_busy,
  output  var logic [corebus_pkg::PORT_COUNT-1:0]     o_sresp_valid,
  output  var corebus_pkg::corebus_response_t         o_sresp
);
  logic                           valid;
  corebus_pkg::corebus_response_t resp;
  corebus_pkg::corebus_response_t load_resp;

  always_comb begin
    load_resp = i_resp;
    if ((i_resp.response_type == corebus_pkg::RESP_READ) && !i_resp.error) begin
      load_resp.data = i_rdata;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid <= 1'b0;
    end else if (i_load) begin
      valid <= 1'b1;
    end else if (valid && i_mresp_accept[i_grant_index]) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      resp <= load_resp;
    end
  end

  always_comb begin
    o_sresp_valid = '0;
    if (valid) begin
      o_sresp_valid[i_grant_index] = 1'b1;
    end
    o_sresp = resp;
    o_busy  = valid;
  end
endmodule

// ==== design/corebus_array_memory.sv ====
/*
  Multi-port memory target, top level.
  Unpacks the per-port packed channel vectors into structs, steers
  the accept bits by the grant index and connects the arbiter, the
  controller, the storage and the response router.
*/
`timescale 1ns/1ps
module corebus_array_memory (
  input   var logic                                   i_clk,
  input   var logic                                   i_rst,
  input   var logic [corebus_pkg::PORT_COUNT-1:0]     i_mcmd_valid,
  output  var logic [corebus_pkg::PORT_COUNT-1:0]     o_scmd_accept,
  input   var logic [corebus_pkg::PORT_COUNT-1:0][corebus_pkg::COMMAND_WIDTH-1:0]
                                                      i_mcmd,
  input   var logic [corebus_pkg::PORT_COUNT-1:0]     i_mdata_valid,
  output  var logic [corebus_pkg::PORT_COUNT-1:0]     o_sdata_accept,
  input   var logic [corebus_pkg::PORT_COUNT-1:0][corebus_pkg::WRITE_DATA_WIDTH-1:0]
                                                      i_mdata,
  output  var logic [corebus_pkg::PORT_COUNT-1:0]     o_sresp_valid,
  input   var logic [corebus_pkg::PORT_COUNT-1:0]     i_mresp_accept,
  output  var logic [corebus_pkg::PORT_COUNT-1:0][corebus_pkg::RESPONSE_WIDTH-1:0]
                                                      o_sresp
);
  corebus_pkg::corebus_command_t          mcmd [corebus_pkg::PORT_COUNT];
  corebus_pkg::corebus_write_data_t       mdata [corebus_pkg::PORT_COUNT];
  corebus_pkg::corebus_command_t          command;
  corebus_pkg::corebus_response_t         resp;
  corebus_pkg::corebus_response_t         sresp;
  logic                                   request;
  logic [corebus_pkg::PORT_SEL_WIDTH-1:0] grant_index;
  logic                                   release_grant;
  logic                                   cmd_accept;
  logic                                   data_accept;
  logic                                   mem_write;
  logic                                   mem_read;
  logic [corebus_pkg::MEM_ADDR_WIDTH-1:0] mem_addr;
  logic [corebus_pkg::DATA_WIDTH-1:0]     mem_wdata;
  logic [corebus_pkg::BE_WIDTH-1:0]       mem_be;
  logic [corebus_pkg::DATA_WIDTH-1:0]     mem_rdata;
  logic                                   resp_load;
  logic                                   resp_busy;

  for (genvar i = 0; i < corebus_pkg::PORT_COUNT; ++i) begin : g_port
    assign mcmd[i]           = corebus_pkg::corebus_command_t'(i_mcmd[i]);
    assign mdata[i]          = corebus_pkg::corebus_write_data_t'(i_mdata[i]);
    assign o_scmd_accept[i]  = cmd_accept && (grant_index == i);
    assign o_sdata_accept[i] = data_accept && (grant_index == i);
    assign o_sresp[i]        = sresp;  // Same payload on every lane.
  end

  corebus_request_arbiter u_arbiter (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_mcmd_valid   (i_mcmd_valid),
    .i_mcmd         (mcmd),
    .i_release      (release_grant),
    .o_request      (request),
    .o_grant_index  (grant_index),
    .o_command      (command)
  );

  corebus_memory_controller u_controller (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_request      (request),
    .i_command      (command),
    .i_mdata_valid  (i_mdata_valid[grant_index]),
    .i_mdata        (mdata[grant_index]),
    .i_resp_busy    (resp_busy),
    .o_cmd_accept   (cmd_accept),
    .o_data_accept  (data_accept),
    .o_release      (release_grant),
    .o_mem_write    (mem_write),
    .o_mem_read     (mem_read),
    .o_mem_addr     (mem_addr),
    .o_mem_wdata    (mem_wdata),
    .o_mem_be       (mem_be),
    .o_resp_load    (resp_load),
    .o_resp         (resp)
  );

  corebus_memory_array u_memory (
    .i_clk    (i_clk),
    .i_write  (mem_write),
    .i_read   (mem_read),
    .i_addr   (mem_addr),
    .i_wdata  (mem_wdata),
    .i_be     (mem_be),
    .o_rdata  (mem_rdata)
  );

  corebus_response_router u_router (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_load         (resp_load),
    .i_resp         (resp),
    .i_rdata        (mem_rdata),
    .i_grant_index  (grant_index),
    .i_mresp_accept (i_mresp_accept),
    .o_busy         (resp_busy),
    .o_sresp_valid  (o_sresp_valid),
    .o_sresp        (sresp)
  );
endmodule

// ==== bench/corebus_array_memory_props.sv ====
/*
  Handshake and grant properties, bound to the memory target.
*/
`timescale 1ns/1ps
module corebus_array_memory_props (
  input var logic                                   i_clk,
  input var logic                                   i_rst,
  input var logic [corebus_pkg::PORT_COUNT-1:0]     i_mcmd_valid,
  input var logic [corebus_pkg::PORT_COUNT-1:0]     o_scmd_accept,
  input var logic [corebus_pkg::PORT_COUNT-1:0][corebus_pkg::COMMAND_WIDTH-1:0] i_mcmd,
  input var logic [corebus_pkg::PORT_COUNT-1:0]     o_sdata_accept,
  input var logic [corebus_pkg::PORT_COUNT-1:0]     o_sresp_valid,
  input var logic [corebus_pkg::PORT_COUNT-1:0]     i_mresp_accept,
  input var logic [corebus_pkg::PORT_COUNT-1:0][corebus_pkg::RESPONSE_WIDTH-1:0] o_sresp
);
  logic [corebus_pkg::PORT_COUNT-1:0] owner_mask;  // Port of the last accepted command.

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      owner_mask <= '0;
    end else if (o_scmd_accept != '0) begin
      owner_mask <= o_scmd_accept;
    end
  end

  for (genvar i = 0; i < corebus_pkg::PORT_COUNT; i++) begin : g_port
    a_resp_stable: assert property (@(posedge i_clk) disable iff (i_rst)
      o_sresp_valid[i] && !i_mresp_accept[i] |=> o_sresp_valid[i] && $stable(o_sresp[i]))
      else $error("response on port %0d changed before accept", i);
    a_cmd_stable: assert property (@(posedge i_clk) disable iff (i_rst)
      i_mcmd_valid[i] && !o_scmd_accept[i] |=> i_mcmd_valid[i] && $stable(i_mcmd[i]))
      else $error("command on port %0d changed before accept", i);
  end

  a_resp_owner: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_sresp_valid & ~owner_mask) == '0)
    else $error("response valid set on a port other than the requester");

  a_reset_quiet: assert property (@(posedge i_clk)
    i_rst |=> (o_scmd_accept == '0) && (o_sdata_accept == '0) && (o_sresp_valid == '0))
    else $error("accept or valid outputs high after reset");
endmodule

bind corebus_array_memory corebus_array_memory_props u_props (
  .i_clk          (i_clk),
  .i_rst          (i_rst),
  .i_mcmd_valid   (i_mcmd_valid),
  .o_scmd_accept  (o_scmd_accept),
  .i_mcmd         (i_mcmd),
  .o_sdata_accept (o_sdata_accept),
  .o_sresp_valid  (o_sresp_valid),
  .i_mresp_accept (i_mresp_accept),
  .o_sresp        (o_sresp)
);

// ==== bench/corebus_array_memory_tb.sv ====
/*
  Testbench for the multi-port memory target.
  Clock, reset, per-port command and data drivers, shadow memory
  with a reference response function, a response monitor with
  typed compare tasks, a watchdog and the closing report.
*/
`timescale 1ns/1ps
module corebus_array_memory_tb;
  localparam realtime CLK_PERIOD = 100ns;
  localparam int P = corebus_pkg::PORT_COUNT;
  // Rough length of each test in cycles, summed.
  localparam int TEST_CYCLES = 20 + 30 + 60 + 60 + 80 + 400;

  logic                                           i_clk;
  logic                                           i_rst;
  logic [P-1:0]                                   i_mcmd_valid;
  logic [P-1:0]                                   o_scmd_accept;
  logic [P-1:0][corebus_pkg::COMMAND_WIDTH-1:0]   i_mcmd;
  logic [P-1:0]                                   i_mdata_valid;
  logic [P-1:0]                                   o_sdata_accept;
  logic [P-1:0][corebus_pkg::WRITE_DATA_WIDTH-1:0] i_mdata;
  logic [P-1:0]                                   o_sresp_valid;
  logic [P-1:0]                                   i_mresp_accept;
  logic [P-1:0][corebus_pkg::RESPONSE_WIDTH-1:0]  o_sresp;

  logic [corebus_pkg::DATA_WIDTH-1:0] shadow [corebus_pkg::MEM_DEPTH];
  corebus_pkg::corebus_response_t     exp_q [P][$];
  int                                 grant_log [$];
  int                                 owner;
  int                                 seed = 32'hf4e8;
  int                                 errors;
  int                                 start_errors;
  int                                 tests;
  logic                               stall_mode;

  corebus_array_memory UUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(TEST_CYCLES * 4 * CLK_PERIOD);
    $display("Timeout: the run did not finish in %0d cycles.", TEST_CYCLES * 4);
    $display("tests failed");
    $finish;
  end

  function automatic corebus_pkg::corebus_response_t expected_response(
    input corebus_pkg::corebus_command_t cmd, input int beat);
    corebus_pkg::corebus_response_t r;
    int addr;
    addr   = int'(cmd.address) + beat;
    r.id   = cmd.id;
    r.last = (beat == int'(cmd.length));
    if (cmd.command_type == corebus_pkg::CMD_WRITE) begin
      r.response_type = corebus_pkg::RESP_WRITE;
      r.data          = '0;
      // Any beat of the burst past the end flags the write.
      r.error = (int'(cmd.address) + int'(cmd.length)) >= corebus_pkg::MEM_DEPTH;
    end else begin
      r.response_type = corebus_pkg::RESP_READ;
      r.error         = addr >= corebus_pkg::MEM_DEPTH;
      r.data          = r.error ? '0 : shadow[addr];
    end
    return r;
  endfunction

  task automatic shadow_write(input int addr, input logic [31:0] data, input logic [3:0] be);
    if (addr < corebus_pkg::MEM_DEPTH) begin
      for (int b = 0; b < corebus_pkg::BE_WIDTH; b++) begin
        if (be[b]) shadow[addr][b*8+:8] = data[b*8+:8];
      end
    end
  endtask

  task automatic check_response(input string name, input corebus_pkg::corebus_response_t exp,
                                input corebus_pkg::corebus_response_t act);
    if (act !== exp) begin
      errors++;
      $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_port(input string name, input logic [P-1:0] exp,
                            input logic [P-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // Sends one command on a port and waits until all its responses are taken.
  task automatic run_command(input int p, input corebus_pkg::corebus_command_type_e kind,
                             input int addr, input int len, input logic [3:0] be);
    corebus_pkg::corebus_command_t    cmd;
    corebus_pkg::corebus_write_data_t beat;
    logic [31:0]                      wdata [4];
    cmd.command_type = kind;
    cmd.id           = corebus_pkg::ID_WIDTH'(p * 8 + ($random(seed) & 7));
    cmd.address      = corebus_pkg::ADDR_WIDTH'(addr);
    cmd.length       = corebus_pkg::LEN_WIDTH'(len);
    for (int b = 0; b <= len; b++) begin
      wdata[b] = $random(seed);
      if (kind == corebus_pkg::CMD_WRITE) begin
        shadow_write(addr + b, wdata[b], be);
      end else begin
        exp_q[p].push_back(expected_response(cmd, b));
      end
    end
    if (kind == corebus_pkg::CMD_WRITE) exp_q[p].push_back(expected_response(cmd, len));
    @(negedge i_clk);
    i_mcmd[p]       = cmd;
    i_mcmd_valid[p] = 1'b1;
    do @(posedge i_clk); while (!o_scmd_accept[p]);
    @(negedge i_clk);
    i_mcmd_valid[p] = 1'b0;
    if (kind == corebus_pkg::CMD_WRITE) begin
      for (int b = 0; b <= len; b++) begin
        beat.data        = wdata[b];
        beat.byte_enable = be;
        beat.last        = (b == len);
        i_mdata[p]       = beat;
        i_mdata_valid[p] = 1'b1;
        do @(posedge i_clk); while (!o_sdata_accept[p]);
        @(negedge i_clk);
      end
      i_mdata_valid[p] = 1'b0;
    end
    while (exp_q[p].size() != 0) @(negedge i_clk);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == start_errors) $display("test %0d %s: ok", tests, name);
    else $display("test %0d %s: %0d errors", tests, name, errors - start_errors);
    start_errors = errors;
  endtask

  // Response monitor, one transfer per rising edge.
  initial begin
    logic [P-1:0]                   exp_valid;
    corebus_pkg::corebus_response_t exp_resp;
    forever begin
      @(posedge i_clk);
      if (!i_rst) begin
        if (o_sresp_valid != '0) begin
          exp_valid        = '0;
          exp_valid[owner] = 1'b1;
          check_port("o_sresp_valid", exp_valid, o_sresp_valid);
          if (i_mresp_accept[owner]) begin
            if (exp_q[owner].size() == 0) begin
              errors++;
              $display("Port %0d returned a response that was not expected at %0t.",
                       owner, $time);
            end else begin
              exp_resp = exp_q[owner].pop_front();
              for (int lane = 0; lane < P; lane++) begin  // Every lane carries it.
                check_response($sformatf("o_sresp[%0d]", lane), exp_resp,
                               corebus_pkg::corebus_response_t'(o_sresp[lane]));
              end
            end
          end
        end
        for (int p = 0; p < P; p++) begin
          if (o_scmd_accept[p]) begin
            owner = p;
            grant_log.push_back(p);
          end
        end
      end
    end
  end

  // Response accept, random while stalling.
  initial begin
    logic [P-1:0] next_accept;
    forever begin
      @(posedge i_clk);
      next_accept = stall_mode ? P'($random(seed)) : '1;
      @(negedge i_clk);
      i_mresp_accept = next_accept;
    end
  end

  initial begin
    int addr;
    int first_port;
    i_rst          = 1'b1;
    i_mcmd_valid   = '0;
    i_mcmd         = '0;
    i_mdata_valid  = '0;
    i_mdata        = '0;
    i_mresp_accept = '1;
    stall_mode     = 1'b0;
    owner          = 0;
    errors         = 0;
    start_errors   = 0;
    tests          = 0;
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;

    run_command(0, corebus_pkg::CMD_WRITE, 5, 0, 4'hf);
    run_command(0, corebus_pkg::CMD_READ, 5, 0, 4'hf);
    end_test("single write and read");

    run_command(0, corebus_pkg::CMD_WRITE, 12, 0, 4'hf);
    run_command(1, corebus_pkg::CMD_WRITE, 12, 0, 4'b0101);
    run_command(0, corebus_pkg::CMD_READ, 12, 0, 4'hf);
    end_test("byte enables");

    run_command(1, corebus_pkg::CMD_WRITE, 8, 3, 4'hf);
    run_command(1, corebus_pkg::CMD_READ, 8, 3, 4'hf);
    end_test("four beat bursts");

    run_command(0, corebus_pkg::CMD_WRITE, 0, 1, 4'hf);
    run_command(0, corebus_pkg::CMD_WRITE, 62, 3, 4'hf);
    run_command(0, corebus_pkg::CMD_READ, 62, 3, 4'hf);
    run_command(0, corebus_pkg::CMD_READ, 0, 1, 4'hf);  // Wrapped beats must not land here.
    end_test("burst past the end");

    first_port = (grant_log[$] + 1) % P;  // Last winner drops to lowest priority.
    grant_log.delete();
    fork
      begin
        run_command(0, corebus_pkg::CMD_WRITE, 20, 1, 4'hf);
        run_command(0, corebus_pkg::CMD_READ, 30, 1, 4'hf);
      end
      begin
        run_command(1, corebus_pkg::CMD_WRITE, 30, 1, 4'hf);
        run_command(1, corebus_pkg::CMD_READ, 20, 1, 4'hf);
      end
    join
    if (grant_log.size() != 4) begin
      errors++;
      $display("Expected 4 grants in the shared test, saw %0d.", grant_log.size());
    end
    if (grant_log.size() > 0 && grant_log[0] != first_port) begin
      errors++;
      $display("First grant went to port %0d instead of port %0d.", grant_log[0], first_port);
    end
    for (int i = 1; i < grant_log.size(); i++) begin
      if (grant_log[i] == grant_log[i-1]) begin
        errors++;
        $display("Grant %0d went to port %0d again instead of alternating.",
                 i, grant_log[i]);
      end
    end
    end_test("round robin");

    stall_mode = 1'b1;
    for (int k = 0; k < 6; k++) begin
      addr = int'($unsigned($random(seed)) % 60);
      run_command(k % P, corebus_pkg::CMD_WRITE, addr, 3, 4'hf);
      run_command((k + 1) % P, corebus_pkg::CMD_READ, addr, 3, 4'hf);
    end
    stall_mode = 1'b0;
    end_test("response back-pressure");

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end
endmodule

// ==== list.f ====
design/corebus_pkg.sv
design/corebus_request_arbiter.sv
design/corebus_memory_controller.sv
design/corebus_memory_array.sv
design/corebus_response_router.sv
design/corebus_array_memory.sv
bench/corebus_array_memory_props.sv
bench/corebus_array_memory_tb.sv

// ==== Makefile ====
TOOL     = verilator
TOP      = corebus_array_memory_tb
FILELIST = list.f
FLAGS    = --binary --timing --assert
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
